/* hdl/video_pkg.sv */
package video_pkg;

	// ============================================================
	// colour channels and scanline strength
	// ============================================================

	typedef logic [2:0] chan3_t; // game side colour depth.
	typedef logic [5:0] chan6_t; // board side colour depth.

	typedef logic [1:0] scan_mode_t;

	localparam scan_mode_t SCAN_NONE = 2'd0; // odd lines untouched.
	localparam scan_mode_t SCAN_25   = 2'd1; // a quarter removed.
	localparam scan_mode_t SCAN_50   = 2'd2; // half removed.
	localparam scan_mode_t SCAN_75   = 2'd3; // a quarter kept.

	// ============================================================
	// pixel formats along the video path
	// ============================================================

	typedef struct packed {
		chan3_t     red;
		chan3_t     green;
		logic [1:0] blue;   // the game only has two blue bits.
		logic       hblank;
		logic       vblank;
		logic       hs;
		logic       vs;
	} game_pixel_t;

	typedef struct packed {
		chan3_t red;
		chan3_t green;
		chan3_t blue;
		logic   de;         // high on visible pixels.
		logic   hs;
		logic   vs;
	} mid_pixel_t;

	typedef struct packed {
		chan6_t red;
		chan6_t green;
		chan6_t blue;
		logic   de;
		logic   hs;
		logic   vs;
	} board_pixel_t;

endpackage

/* hdl/pixel_blank.sv */
`timescale 1ns/1ps

module pixel_blank (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  video_pkg::game_pixel_t pix_in,
	input  logic                  in_valid,
	output logic                  in_ready,
	output video_pkg::mid_pixel_t  pix_out,
	output logic                  out_valid,
	input  logic                  out_ready
);

	import video_pkg::*;

	logic       de;
	logic       load;
	chan3_t     blue_wide;
	mid_pixel_t pix_next;

	assign de        = ~(pix_in.hblank | pix_in.vblank);
	assign blue_wide = {pix_in.blue, pix_in.blue[0]}; // low bit repeated below.

	always_comb begin
		pix_next.red   = de ? pix_in.red   : '0;
		pix_next.green = de ? pix_in.green : '0;
		pix_next.blue  = de ? blue_wide    : '0;
		pix_next.de    = de;
		pix_next.hs    = pix_in.hs;
		pix_next.vs    = pix_in.vs;
	end

	// ============================================================
	// output register
	// ============================================================

	assign in_ready = ~out_valid | out_ready; // room now or space freed this cycle.
	assign load     = in_valid & in_ready;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (load) begin
			pix_out <= pix_next;
		end
	end

endmodule

/* hdl/color_expand.sv */
`timescale 1ns/1ps

module color_expand (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  video_pkg::mid_pixel_t   pix_in,
	input  logic                   in_valid,
	output logic                   in_ready,
	output video_pkg::board_pixel_t pix_out,
	output logic                   out_valid,
	input  logic                   out_ready
);

	import video_pkg::*;

	logic         load;
	board_pixel_t pix_next;

	// writing the bits twice maps 3'b111 to 6'b111111, so white stays white.
	function automatic chan6_t widen(input chan3_t c);
		return {c, c};
	endfunction

	always_comb begin
		pix_next.red   = widen(pix_in.red);
		pix_next.green = widen(pix_in.green);
		pix_next.blue  = widen(pix_in.blue);
		pix_next.de    = pix_in.de;
		pix_next.hs    = pix_in.hs;
		pix_next.vs    = pix_in.vs;
	end

	assign in_ready = ~out_valid | out_ready;
	assign load     = in_valid & in_ready;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0; // item taken and nothing new behind it.
		end
	end

	always_ff @(posedge clk_sys) begin
		if (load) begin
			pix_out <= pix_next;
		end
	end

endmodule

/* hdl/scanline_fx.sv */
`timescale 1ns/1ps

module scanline_fx (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  video_pkg::board_pixel_t pix_in,
	input  logic                   in_valid,
	output logic                   in_ready,
	output video_pkg::board_pixel_t pix_out,
	output logic                   out_valid,
	input  logic                   out_ready,
	input  video_pkg::scan_mode_t   scan_mode,
	input  logic                   blend
);

	import video_pkg::*;

	logic         load;
	logic         prev_hs;
	logic         odd_line;
	logic         hist_valid;
	logic         line_start;
	logic         odd_next;
	logic         use_self;
	chan6_t       prev_red;
	chan6_t       prev_green;
	chan6_t       prev_blue;
	board_pixel_t pix_next;

	// ============================================================
	// per channel arithmetic
	// ============================================================

	function automatic chan6_t mean_chan(input chan6_t a, input chan6_t b);
		logic [6:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		return sum[6:1];
	endfunction

	function automatic chan6_t dim_chan(input chan6_t c, input scan_mode_t mode);
		chan6_t res;
		case (mode)
			SCAN_25: res = c - (c >> 2);
			SCAN_50: res = c >> 1;
			SCAN_75: res = c >> 2;
			default: res = c;
		endcase
		return res;
	endfunction

	function automatic chan6_t shade(input chan6_t c, input chan6_t prev,
		input logic self_nb, input logic odd, input logic de);
		chan6_t nb;
		chan6_t mixed;
		chan6_t res;
		nb    = self_nb ? c : prev;
		mixed = blend ? mean_chan(c, nb) : c;
		res   = odd ? dim_chan(mixed, scan_mode) : mixed;
		return de ? res : '0;
	endfunction

	// ============================================================
	// line tracking
	// ============================================================

	assign line_start = pix_in.hs & ~prev_hs;
	assign odd_next   = pix_in.vs ? 1'b0 : (line_start ? ~odd_line : odd_line);
	assign use_self   = line_start | ~hist_valid; // first pixel is its own neighbour.

	always_comb begin
		pix_next.red   = shade(pix_in.red, prev_red, use_self, odd_next, pix_in.de);
		pix_next.green = shade(pix_in.green, prev_green, use_self, odd_next, pix_in.de);
		pix_next.blue  = shade(pix_in.blue, prev_blue, use_self, odd_next, pix_in.de);
		pix_next.de    = pix_in.de;
		pix_next.hs    = pix_in.hs;
		pix_next.vs    = pix_in.vs;
	end

	assign in_ready = ~out_valid | out_ready;
	assign load     = in_valid & in_ready;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			out_valid  <= 1'b0;
			prev_hs    <= 1'b0;
			odd_line   <= 1'b0;
			hist_valid <= 1'b0;
			prev_red   <= '0;
			prev_green <= '0;
			prev_blue  <= '0;
		end else begin
			if (load) begin
				out_valid  <= 1'b1;
				prev_hs    <= pix_in.hs;
				odd_line   <= odd_next;
				hist_valid <= 1'b1;
				prev_red   <= pix_in.red;   // the raw input is the neighbour.
				prev_green <= pix_in.green;
				prev_blue  <= pix_in.blue;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (load) begin
			pix_out <= pix_next;
		end
	end

endmodule

/* hdl/sigma_delta_dac.sv */
`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int DAC_BITS = 16
) (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  logic signed [DAC_BITS-1:0] sample,
	output logic                       dac_out
);

	typedef logic [DAC_BITS-1:0] level_t;
	typedef logic [DAC_BITS:0]   acc_t;

	level_t level;
	acc_t   acc;
	acc_t   acc_next;

	// flipping the sign bit moves the signed range onto 0 .. 2**DAC_BITS-1.
	assign level = {~sample[DAC_BITS-1], sample[DAC_BITS-2:0]};

	// the carry is dropped before the next sum, so only the residue integrates.
	assign acc_next = {1'b0, acc[DAC_BITS-1:0]} + {1'b0, level};

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
	end

	assign dac_out = acc[DAC_BITS]; // one carry per overflow of the residue.

endmodule

/* hdl/arcade_av_out.sv */
`timescale 1ns/1ps

module arcade_av_out #(
	parameter int DAC_BITS = 16
) (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  video_pkg::game_pixel_t      pix_in,
	input  logic                       pix_in_valid,
	output logic                       pix_in_ready,
	output video_pkg::board_pixel_t     pix_out,
	output logic                       pix_out_valid,
	input  logic                       pix_out_ready,
	input  video_pkg::scan_mode_t       scan_mode,
	input  logic                       blend,
	input  logic signed [DAC_BITS-1:0] audio,
	output logic                       audio_out
);

	import video_pkg::*;

	mid_pixel_t   blank_pix;
	logic         blank_valid;
	logic         blank_ready;
	board_pixel_t expand_pix;
	logic         expand_valid;
	logic         expand_ready;

	// ============================================================
	// video path
	// ============================================================

	pixel_blank i_blank (
		.clk_sys   ( clk_sys      ),
		.rst       ( rst          ),
		.pix_in    ( pix_in       ),
		.in_valid  ( pix_in_valid ),
		.in_ready  ( pix_in_ready ),
		.pix_out   ( blank_pix    ),
		.out_valid ( blank_valid  ),
		.out_ready ( blank_ready  )
	);

	color_expand i_expand (
		.clk_sys   ( clk_sys      ),
		.rst       ( rst          ),
		.pix_in    ( blank_pix    ),
		.in_valid  ( blank_valid  ),
		.in_ready  ( blank_ready  ),
		.pix_out   ( expand_pix   ),
		.out_valid ( expand_valid ),
		.out_ready ( expand_ready )
	);

	scanline_fx i_scan (
		.clk_sys   ( clk_sys       ),
		.rst       ( rst           ),
		.pix_in    ( expand_pix    ),
		.in_valid  ( expand_valid  ),
		.in_ready  ( expand_ready  ),
		.pix_out   ( pix_out       ),
		.out_valid ( pix_out_valid ),
		.out_ready ( pix_out_ready ),
		.scan_mode ( scan_mode     ),
		.blend     ( blend         )
	);

	// ============================================================
	// audio path
	// ============================================================

	sigma_delta_dac #(.DAC_BITS(DAC_BITS)) i_dac (
		.clk_sys ( clk_sys   ),
		.rst     ( rst       ),
		.sample  ( audio     ),
		.dac_out ( audio_out )
	);

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS   = 40,
	parameter int RESET_TICKS = 4
) (
	output logic clk_sys,
	output logic rst
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_TICKS) @(posedge clk_sys);
		rst <= 1'b0; // released after the fourth rising edge.
	end

endmodule

/* tests/tb_arcade_av_out.sv */
`timescale 1ns/1ps

module tb_arcade_av_out;

	import video_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int DAC_BITS     = 16;
	localparam int LINES        = 3;  // odd, so only the vs item brings parity back to even.
	localparam int WIDTH        = 8;
	localparam int FRAMES       = 2;
	localparam int PHASES       = 8;
	localparam int FRAME_ITEMS  = 1 + LINES * (WIDTH + 3);
	localparam int TOTAL_ITEMS  = PHASES * FRAMES * FRAME_ITEMS;
	localparam int AUDIO_CYCLES = 4096;
	localparam int AUDIO_LEVELS = 5;
	localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 40 + AUDIO_LEVELS * (AUDIO_CYCLES + 8) + 2000;

	logic                       clk_sys;
	logic                       rst;
	game_pixel_t                pix_in;
	logic                       pix_in_valid;
	logic                       pix_in_ready;
	board_pixel_t               pix_out;
	logic                       pix_out_valid;
	logic                       pix_out_ready;
	scan_mode_t                 scan_mode;
	logic                       blend;
	logic signed [DAC_BITS-1:0] audio;
	logic                       audio_out;

	logic [31:0]  lfsr = 32'h765b_7359;
	game_pixel_t  stim_q[$];
	board_pixel_t exp_q[$];
	logic         mdl_prev_hs;
	logic         mdl_odd;
	logic         mdl_hist;
	board_pixel_t mdl_prev;
	int           n_out;
	int           pixel_errors;
	int           audio_errors;
	int           proto_errors;
	int           audio_values[AUDIO_LEVELS] = '{-32768, -16384, 0, 12345, 32767};

	tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_TICKS(4)) i_clock (
		.clk_sys ( clk_sys ),
		.rst     ( rst     )
	);

	arcade_av_out #(.DAC_BITS(DAC_BITS)) i_arcade_av_out (
		.clk_sys       ( clk_sys       ),
		.rst           ( rst           ),
		.pix_in        ( pix_in        ),
		.pix_in_valid  ( pix_in_valid  ),
		.pix_in_ready  ( pix_in_ready  ),
		.pix_out       ( pix_out       ),
		.pix_out_valid ( pix_out_valid ),
		.pix_out_ready ( pix_out_ready ),
		.scan_mode     ( scan_mode     ),
		.blend         ( blend         ),
		.audio         ( audio         ),
		.audio_out     ( audio_out     )
	);

	// ============================================================
	// random source and stimulus
	// ============================================================

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // taps 32 22 2 1.
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic game_pixel_t random_pixel(input logic hb, input logic vb,
		input logic hs, input logic vs);
		game_pixel_t p;
		p.red    = chan3_t'(take_bits(3));
		p.green  = chan3_t'(take_bits(3));
		p.blue   = 2'(take_bits(2));
		p.hblank = hb;
		p.vblank = vb;
		p.hs     = hs;
		p.vs     = vs;
		return p;
	endfunction

	task automatic build_frame();
		stim_q.push_back(random_pixel(take_bits(1) != 0, 1'b1, 1'b0, 1'b1)); // vblank may stand alone.
		for (int l = 0; l < LINES; l++) begin
			stim_q.push_back(random_pixel(take_bits(1) != 0, 1'b0, 1'b1, 1'b0)); // line start.
			stim_q.push_back(random_pixel(1'b1, 1'b0, 1'b1, 1'b0));
			for (int x = 0; x < WIDTH; x++) begin
				stim_q.push_back(random_pixel(take_bits(3) == 0, 1'b0, 1'b0, 1'b0));
			end
			stim_q.push_back(random_pixel(1'b1, 1'b0, 1'b0, 1'b0));
		end
	endtask

	// ============================================================
	// reference model
	// ============================================================

	function automatic int expected_channel(input int c, input int nb, input logic odd,
		input logic vis);
		int m;
		m = blend ? (c + nb) / 2 : c;
		if (odd) begin
			case (int'(scan_mode))
				1: m = m - m / 4;
				2: m = m / 2;
				3: m = m / 4;
				default: m = m;
			endcase
		end
		return vis ? m : 0;
	endfunction

	function automatic board_pixel_t model_pixel(input game_pixel_t p);
		board_pixel_t w;
		board_pixel_t nb;
		board_pixel_t r;
		logic         vis;
		logic         start;
		int           b3;
		vis     = !(p.hblank || p.vblank);
		b3      = int'(p.blue) * 2 + int'(p.blue[0]);
		w.red   = vis ? chan6_t'(int'(p.red) * 9) : '0; // c*9 is c written twice.
		w.green = vis ? chan6_t'(int'(p.green) * 9) : '0;
		w.blue  = vis ? chan6_t'(b3 * 9) : '0;
		start   = p.hs && !mdl_prev_hs;
		if (p.vs) begin
			mdl_odd = 1'b0;
		end else if (start) begin
			mdl_odd = !mdl_odd;
		end
		nb      = (start || !mdl_hist) ? w : mdl_prev;
		r.red   = chan6_t'(expected_channel(w.red, nb.red, mdl_odd, vis));
		r.green = chan6_t'(expected_channel(w.green, nb.green, mdl_odd, vis));
		r.blue  = chan6_t'(expected_channel(w.blue, nb.blue, mdl_odd, vis));
		r.de    = vis;
		r.hs    = p.hs;
		r.vs    = p.vs;
		mdl_prev    = w;
		mdl_prev_hs = p.hs;
		mdl_hist    = 1'b1;
		return r;
	endfunction

	// ============================================================
	// checks
	// ============================================================

	task automatic check_field(input string name, input logic [5:0] got, input logic [5:0] want);
		assert (got === want) else begin
			pixel_errors++;
			$display("FAIL %0t: %s expected %0d got %0d", $time, name, want, got);
		end
	endtask

	task automatic check_output();
		board_pixel_t exp;
		n_out++;
		assert (exp_q.size() > 0) else begin
			proto_errors++;
			$display("An output pixel appeared at %0t with no pixel left in the model queue.",
				$time);
		end
		if (exp_q.size() > 0) begin
			exp = exp_q.pop_front();
			check_field("red", pix_out.red, exp.red);
			check_field("green", pix_out.green, exp.green);
			check_field("blue", pix_out.blue, exp.blue);
			check_field("de", pix_out.de, exp.de);
			check_field("hs", pix_out.hs, exp.hs);
			check_field("vs", pix_out.vs, exp.vs);
		end
	endtask

	task automatic run_phase(input scan_mode_t mode, input logic blend_on, input logic stress);
		logic sent;
		@(negedge clk_sys);
		scan_mode = mode; // the pipeline is empty here, so no item sees the change early.
		blend     = blend_on;
		for (int f = 0; f < FRAMES; f++) begin
			build_frame();
		end
		sent = 1'b0;
		while (stim_q.size() > 0 || pix_in_valid || exp_q.size() > 0) begin
			@(negedge clk_sys);
			if (sent) begin
				pix_in_valid = 1'b0;
			end
			if (!pix_in_valid && stim_q.size() > 0 && (!stress || take_bits(2) != 0)) begin
				pix_in       = stim_q.pop_front();
				pix_in_valid = 1'b1;
			end
			pix_out_ready = stress ? (take_bits(2) != 0) : 1'b1;
			#5;
			if (pix_out_valid && pix_out_ready) begin
				check_output();
			end
			sent = pix_in_valid && pix_in_ready; // the transfer happens at the next rising edge.
			if (sent) begin
				exp_q.push_back(model_pixel(pix_in));
			end
		end
	endtask

	task automatic check_audio(input int value);
		int     ones;
		longint diff;
		@(negedge clk_sys);
		audio = DAC_BITS'(value);
		repeat (4) @(negedge clk_sys);
		ones = 0;
		repeat (AUDIO_CYCLES) begin
			@(negedge clk_sys);
			if (audio_out) begin
				ones++;
			end
		end
		diff = longint'(ones) * 65536 - longint'(AUDIO_CYCLES) * (value + 32768);
		assert (diff >= -65536 && diff <= 65536) else begin
			audio_errors++;
			$display("FAIL %0t: audio %0d gave %0d ones in %0d cycles", $time, value, ones,
				AUDIO_CYCLES);
		end
	endtask

	initial begin
		#(longint'(WATCHDOG_CYCLES) * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles.", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	initial begin
		pix_in        = '0;
		pix_in_valid  = 1'b0;
		pix_out_ready = 1'b1;
		scan_mode     = SCAN_NONE;
		blend         = 1'b0;
		audio         = -32768; // lowest level keeps the accumulator at zero.
		mdl_prev_hs   = 1'b0;
		mdl_odd       = 1'b0;
		mdl_hist      = 1'b0;
		mdl_prev      = '0;
		n_out         = 0;
		pixel_errors  = 0;
		audio_errors  = 0;
		proto_errors  = 0;
		@(negedge clk_sys);
		while (rst) @(negedge clk_sys);
		repeat (8) begin
			@(negedge clk_sys);
			#5;
			assert (pix_out_valid === 1'b0 && audio_out === 1'b0) else begin
				proto_errors++;
				$display("FAIL %0t: output active after reset before any input", $time);
			end
		end
		for (int ph = 0; ph < PHASES; ph++) begin
			run_phase(scan_mode_t'(ph % 4), ph >= 4, ph >= 2);
		end
		repeat (8) begin
			@(negedge clk_sys);
			pix_out_ready = 1'b1;
			#5;
			if (pix_out_valid) begin
				check_output(); // nothing may follow the last expected pixel.
			end
		end
		assert (n_out == TOTAL_ITEMS) else begin
			proto_errors++;
			$display("The video path delivered %0d of %0d pixels.", n_out, TOTAL_ITEMS);
		end
		for (int a = 0; a < AUDIO_LEVELS; a++) begin
			check_audio(audio_values[a]);
		end
		$display("errors: %0d pixel, %0d audio, %0d protocol", pixel_errors, audio_errors,
			proto_errors);
		if (pixel_errors + audio_errors + proto_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* list.f */
hdl/video_pkg.sv
hdl/pixel_blank.sv
hdl/color_expand.sv
hdl/scanline_fx.sv
hdl/sigma_delta_dac.sv
hdl/arcade_av_out.sv
tests/tb_clock.sv
tests/tb_arcade_av_out.sv

/* Bender.yml */
package:
  name: arcade_av_out

sources:
  - hdl/video_pkg.sv
  - hdl/pixel_blank.sv
  - hdl/color_expand.sv
  - hdl/scanline_fx.sv
  - hdl/sigma_delta_dac.sv
  - hdl/arcade_av_out.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_arcade_av_out.sv
